// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_top -Mdir obj_dir -f cache_sys.f

run: compile
	./obj_dir/Vtb_top | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cache_sys.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/line_memory.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           req_valid,
  output logic          req_ready,
  input  wire cpu_req_t req,
  output logic          rsp_valid,
  input  wire           rsp_ready,
  output cpu_rsp_t      rsp,
  output logic          mem_req_valid,
  input  wire           mem_req_ready,
  output mem_req_t      mem_req,
  input  wire           mem_rsp_valid,
  input  wire line_t    mem_rsp_line
);

  // cache arrays
  line_t                data_arr [`NUM_SETS];
  logic [`TAG_BITS-1:0] tag_arr  [`NUM_SETS];
  logic [`NUM_SETS-1:0] valid_bits;
  logic [`NUM_SETS-1:0] dirty_bits;

  ctrl_state_t state;
  cpu_req_t    req_q;
  // sticky, set once the current access needed a refill
  logic        missed;

  logic [`TAG_BITS-1:0]   req_tag;
  logic [`INDEX_BITS-1:0] req_idx;
  logic [1:0]             req_word;
  logic                   hit_now;
  logic                   victim_dirty;
  line_t                  cur_line;
  line_t                  merged_line;
  logic [31:0]            cur_word;

  // split the held address
  assign req_tag  = req_q.addr[`ADDR_BITS-1 -: `TAG_BITS];
  assign req_idx  = req_q.addr[`ADDR_BITS-`TAG_BITS-1 -: `INDEX_BITS];
  assign req_word = req_q.addr[3:2];

  // one request in flight, next one only after the response is taken
  assign req_ready = (state == idle) && !rsp_valid;

  assign cur_line     = data_arr[req_idx];
  assign cur_word     = cur_line[req_word*32 +: 32];
  assign hit_now      = valid_bits[req_idx] && (tag_arr[req_idx] == req_tag);
  assign victim_dirty = valid_bits[req_idx] && dirty_bits[req_idx];

  // write data merged into the selected word
  always_comb begin
    merged_line = cur_line;
    for (int w = 0; w < `LINE_WORDS; w++) begin
      if (int'(req_word) == w) begin
        merged_line[w*32 +: 32] = req_q.wdata;
      end
    end
  end

  // miss FSM and status bits
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= idle;
      rsp_valid     <= 1'b0;
      mem_req_valid <= 1'b0;
      missed        <= 1'b0;
      valid_bits    <= '0;
      dirty_bits    <= '0;
    end else begin
      if (rsp_valid && rsp_ready) begin
        rsp_valid <= 1'b0;
      end
      if (mem_req_valid && mem_req_ready) begin
        mem_req_valid <= 1'b0;
      end
      case (state)
        idle: begin
          if (req_valid && req_ready) begin
            missed <= 1'b0;
            state  <= compare;
          end
        end
        compare: begin
          if (hit_now) begin
            if (req_q.write) begin
              dirty_bits[req_idx] <= 1'b1;
            end
            rsp_valid <= 1'b1;
            state     <= idle;
          end else begin
            missed        <= 1'b1;
            mem_req_valid <= 1'b1;
            // dirty victim goes out before the refill
            if (victim_dirty) begin
              state <= write_back;
            end else begin
              state <= allocate;
            end
          end
        end
        write_back: begin
          if (mem_rsp_valid) begin
            mem_req_valid <= 1'b1;
            state         <= allocate;
          end
        end
        allocate: begin
          if (mem_rsp_valid) begin
            valid_bits[req_idx] <= 1'b1;
            dirty_bits[req_idx] <= 1'b0;
            state               <= compare;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // request, arrays, response and memory payload
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    case (state)
      compare: begin
        if (hit_now) begin
          if (req_q.write) begin
            data_arr[req_idx] <= merged_line;
          end
          rsp.rdata <= req_q.write ? req_q.wdata : cur_word;
          rsp.hit   <= !missed;
        end else begin
          mem_req.write <= victim_dirty;
          mem_req.wline <= cur_line;
          if (victim_dirty) begin
            mem_req.line_addr <= {tag_arr[req_idx], req_idx};
          end else begin
            mem_req.line_addr <= {req_tag, req_idx};
          end
        end
      end
      write_back: begin
        if (mem_rsp_valid) begin
          mem_req.write     <= 1'b0;
          mem_req.line_addr <= {req_tag, req_idx};
        end
      end
      allocate: begin
        // refill line and tag
        if (mem_rsp_valid) begin
          data_arr[req_idx] <= mem_rsp_line;
          tag_arr[req_idx]  <= req_tag;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address fields, tag on top then index then word
`define ADDR_BITS   12
`define TAG_BITS    4
`define INDEX_BITS  4

// direct-mapped cache geometry
`define NUM_SETS    16
`define LINE_WORDS  4
`define LINE_BITS   128

// backing memory holds the full 4 KB space
`define MEM_LINES   256

// cycles from memory accept to memory response
`define MEM_LATENCY 4

`endif

// ==== hdl/cache_pkg.sv ====
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  typedef logic [`LINE_BITS-1:0] line_t;

  // processor request
  typedef struct packed {
    logic [`ADDR_BITS-1:0] addr;
    logic                  write;
    logic [31:0]           wdata;
  } cpu_req_t;

  // processor response
  typedef struct packed {
    logic [31:0] rdata;
    logic        hit;
  } cpu_rsp_t;

  // whole-line transfer to the backing memory
  typedef struct packed {
    logic [`TAG_BITS+`INDEX_BITS-1:0] line_addr;
    logic                             write;
    line_t                            wline;
  } mem_req_t;

  typedef enum logic [1:0] {
    idle,
    compare,
    write_back,
    allocate
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top
  import cache_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           req_valid,
  output logic          req_ready,
  input  wire cpu_req_t req,
  output logic          rsp_valid,
  input  wire           rsp_ready,
  output cpu_rsp_t      rsp
);

  // controller to memory
  wire           mem_req_valid;
  wire           mem_req_ready;
  wire mem_req_t mem_req;
  wire           mem_rsp_valid;
  wire line_t    mem_rsp_line;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_line  (mem_rsp_line)
  );

  line_memory u_mem (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_line  (mem_rsp_line)
  );

endmodule

`default_nettype wire

// ==== hdl/line_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module line_memory
  import cache_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           mem_req_valid,
  output logic          mem_req_ready,
  input  wire mem_req_t mem_req,
  output logic          mem_rsp_valid,
  output line_t         mem_rsp_line
);

  localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

  line_t               mem_array [`MEM_LINES];
  logic                busy;
  logic [CNT_BITS-1:0] count;
  logic                accept;

  // memory starts out all zero
  initial begin
    for (int i = 0; i < `MEM_LINES; i++) begin
      mem_array[i] = '0;
    end
  end

  assign mem_req_ready = !busy;
  assign accept        = mem_req_valid && mem_req_ready;

  // writes land on the accepting edge, read data is captured then
  always @(posedge clk) begin
    if (accept) begin
      mem_rsp_line <= mem_array[mem_req.line_addr];
      if (mem_req.write) begin
        mem_array[mem_req.line_addr] <= mem_req.wline;
      end
    end
  end

  // latency countdown
  always_ff @(posedge clk) begin
    if (reset) begin
      busy          <= 1'b0;
      count         <= '0;
      mem_rsp_valid <= 1'b0;
    end else begin
      mem_rsp_valid <= 1'b0;
      if (accept) begin
        busy  <= 1'b1;
        count <= CNT_BITS'(`MEM_LATENCY - 1);
      end else if (busy) begin
        if (count == '0) begin
          // one-cycle response pulse
          busy          <= 1'b0;
          mem_rsp_valid <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module tb_checker
  import cache_pkg::*;
(
  input  wire           clk,
  input  wire           reset,
  input  wire           req_valid,
  input  wire           req_ready,
  input  wire cpu_req_t req,
  input  wire           rsp_valid,
  input  wire           rsp_ready,
  input  wire cpu_rsp_t rsp,
  output int            errors,
  output int            checked
);

  localparam int NUM_WORDS = `MEM_LINES * `LINE_WORDS;

  // reference model of memory words and cache tags
  logic [31:0]          model_words [NUM_WORDS];
  logic [`TAG_BITS-1:0] model_tag   [`NUM_SETS];
  logic                 model_valid [`NUM_SETS];

  // predictions waiting for their response
  logic [31:0] exp_rdata [$];
  logic        exp_hit   [$];
  logic        exp_write [$];

  logic     prev_reset;
  logic     hold_pending;
  cpu_rsp_t held_rsp;

  initial begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      model_words[i] = '0;
    end
    for (int s = 0; s < `NUM_SETS; s++) begin
      model_tag[s]   = '0;
      model_valid[s] = 1'b0;
    end
    errors       = 0;
    checked      = 0;
    prev_reset   = 1'b0;
    hold_pending = 1'b0;
    held_rsp     = '0;
  end

  always @(posedge clk) begin
    logic [3:0]  tag;
    logic [3:0]  idx;
    logic [9:0]  waddr;
    logic        e_hit;
    logic        e_write;
    logic [31:0] e_rdata;
    if (reset) begin
      if (prev_reset && rsp_valid !== 1'b0) begin
        $display("%0t: rsp_valid is not low during reset", $time);
        errors++;
      end
      hold_pending = 1'b0;
    end else begin
      if (prev_reset && rsp_valid !== 1'b0) begin
        $display("%0t: rsp_valid is not low on the first cycle after reset", $time);
        errors++;
      end
      if (prev_reset && req_ready !== 1'b1) begin
        $display("%0t: req_ready is not high on the first cycle after reset", $time);
        errors++;
      end
      // a stalled response must stay put
      if (hold_pending && rsp_valid !== 1'b1) begin
        $display("%0t: rsp_valid dropped while rsp_ready was low", $time);
        errors++;
      end else if (hold_pending && rsp !== held_rsp) begin
        $display("%0t: rsp changed while rsp_ready was low", $time);
        errors++;
      end
      // no new request may be taken while a response is pending
      if (rsp_valid && req_ready !== 1'b0) begin
        $display("%0t: req_ready is high while a response is pending", $time);
        errors++;
      end
      if (req_valid && req_ready) begin
        tag   = req.addr[11:8];
        idx   = req.addr[7:4];
        waddr = req.addr[11:2];
        exp_hit.push_back(model_valid[idx] && model_tag[idx] == tag);
        exp_rdata.push_back(model_words[waddr]);
        exp_write.push_back(req.write);
        if (req.write) begin
          model_words[waddr] = req.wdata;
        end
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
      end
      if (rsp_valid && rsp_ready) begin
        if (exp_hit.size() == 0) begin
          $display("%0t: response arrived with no request outstanding", $time);
          errors++;
        end else begin
          e_hit   = exp_hit.pop_front();
          e_rdata = exp_rdata.pop_front();
          e_write = exp_write.pop_front();
          checked++;
          if (rsp.hit !== e_hit) begin
            $display("MISMATCH at %0t: rsp.hit expected %0b, got %0b", $time, e_hit, rsp.hit);
            errors++;
          end
          // only reads return a word from memory
          if (!e_write && rsp.rdata !== e_rdata) begin
            $display("MISMATCH at %0t: rsp.rdata expected %08h, got %08h",
                     $time, e_rdata, rsp.rdata);
            errors++;
          end
        end
      end
      hold_pending = rsp_valid && !rsp_ready;
      held_rsp     = rsp;
    end
    prev_reset = reset;
  end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_defs.svh"

module tb_top
  import cache_pkg::*;
();

  localparam int CLK_NS     = 100;
  localparam int RESET_CYC  = 10;
  localparam int TOTAL_REQS = 64 + 64 + 128 + 400;
  // every request budgeted as a dirty miss
  localparam int LIMIT_CYC  = TOTAL_REQS * (2 * `MEM_LATENCY + 8) + RESET_CYC;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  cpu_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  cpu_rsp_t    rsp;
  int          errors;
  int          checked;
  logic        random_ready;
  logic [31:0] lfsr_state = 32'h8584_89af;

  tb_clock clk_gen (
    .clk (clk)
  );

  cache_top dut (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  tb_checker chk (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .errors    (errors),
    .checked   (checked)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // few tags so that sets conflict often
  function automatic logic [3:0] pick_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 4'h1;
      2'd1:    return 4'h6;
      2'd2:    return 4'ha;
      default: return 4'hd;
    endcase
  endfunction

  function automatic logic [11:0] random_addr();
    logic [31:0] bits;
    bits = rand_bits(8);
    return {pick_tag(bits[7:6]), bits[5:2], bits[1:0], 2'b00};
  endfunction

  task automatic drive_ready();
    if (random_ready) begin
      rsp_ready <= (rand_bits(2) != 32'd0);
    end else begin
      rsp_ready <= 1'b1;
    end
  endtask

  // hold the request until accepted, then wait for its response
  task automatic issue_request(input logic [11:0] addr, input logic write,
                               input logic [31:0] wdata);
    logic done;
    req_valid <= 1'b1;
    req       <= '{addr: addr, write: write, wdata: wdata};
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = req_ready;
      drive_ready();
    end
    req_valid <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = rsp_valid && rsp_ready;
      drive_ready();
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    @(posedge clk);
    $display("test %s done, %0d errors", name, errors - errs_before);
  endtask

  initial begin
    int          errs_before;
    logic [31:0] bits;
    logic [11:0] addr;
    logic [11:0] other;
    logic [31:0] data;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b1;
    random_ready = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    reset <= 1'b0;

    errs_before = errors;
    for (int i = 0; i < 64; i++) begin
      issue_request(random_addr(), 1'b0, 32'd0);
    end
    report_test("cold reads", errs_before);

    errs_before = errors;
    for (int i = 0; i < 16; i++) begin
      addr = random_addr();
      data = rand_bits(32);
      issue_request(addr, 1'b1, data);
      repeat (3) issue_request(addr, 1'b0, 32'd0);
    end
    report_test("write then read-back", errs_before);

    // write, read, evict with another tag, read again
    errs_before = errors;
    for (int i = 0; i < 32; i++) begin
      bits  = rand_bits(8);
      addr  = {pick_tag(bits[7:6]), bits[5:2], bits[1:0], 2'b00};
      other = {pick_tag(bits[7:6] + 2'd1), bits[5:2], 4'b0000};
      data  = rand_bits(32);
      issue_request(addr, 1'b1, data);
      issue_request(addr, 1'b0, 32'd0);
      issue_request(other, 1'b0, 32'd0);
      issue_request(addr, 1'b0, 32'd0);
    end
    report_test("conflict eviction", errs_before);

    errs_before  = errors;
    random_ready = 1'b1;
    for (int i = 0; i < 400; i++) begin
      bits = rand_bits(1);
      addr = random_addr();
      data = rand_bits(32);
      issue_request(addr, bits[0], data);
    end
    random_ready = 1'b0;
    rsp_ready <= 1'b1;
    report_test("random mix", errs_before);

    if (checked != TOTAL_REQS) begin
      $display("only %0d of %0d responses were checked", checked, TOTAL_REQS);
    end
    $display("run done: %0d responses checked, %0d errors", checked, errors);
    if (errors == 0 && checked == TOTAL_REQS) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(LIMIT_CYC * CLK_NS);
    $display("timeout, run did not finish within %0d cycles", LIMIT_CYC);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
